//--- hw/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ####################################################################
// address space.
// ####################################################################

`define FETCH_ADDR_W 32

// cacheable window, limit is exclusive.
`define FETCH_SDRAM_BASE  32'ha000_0000
`define FETCH_SDRAM_LIMIT 32'ha200_0000

// ####################################################################
// cache geometry.
// ####################################################################

// one line is one memory burst.
`define FETCH_LINE_WORDS  4
`define FETCH_CACHE_LINES 16

`endif

//--- hw/fetch_bus_pkg.sv
`include "fetch_defines.svh"

package fetch_bus_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// burst types used on the memory port.
	localparam logic [1:0] BURST_FIXED = 2'b00;
	localparam logic [1:0] BURST_INCR  = 2'b01;

	// memory port, full axi4 read.
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] addr;
		logic [1:0]               burst;
		logic [3:0]               len;
	} axi_ar_t;

	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] data;
		logic [1:0]               resp;
		logic                     last;
	} axi_r_t;

	// cache port, axi4-lite.
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] data;
		logic [1:0]               resp;
	} axil_r_t;

	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0]   data;
		logic [`FETCH_ADDR_W/8-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

endpackage

//--- hw/fetch_core_pkg.sv
`include "fetch_defines.svh"

package fetch_core_pkg;

	// request from the core.
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] pc;
	} fetch_req_t;

	// fetched instruction back to the core.
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] inst;
	} fetch_rsp_t;

	// fetch unit FSM.
	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		LOOKUP   = 3'd1,
		MEM_REQ  = 3'd2,
		MEM_DATA = 3'd3,
		DONE     = 3'd4
	} ifu_state_e;

endpackage

//--- hw/icache.sv
`timescale 1ns/10ps
`include "fetch_defines.svh"

module icache #(
	parameter int num_lines = `FETCH_CACHE_LINES
) (
	input  logic                    clock,
	input  logic                    reset,
	input  fetch_bus_pkg::axil_ar_t ar,
	input  logic                    arvalid,
	output logic                    arready,
	output fetch_bus_pkg::axil_r_t  r,
	output logic                    rvalid,
	input  logic                    rready,
	input  fetch_bus_pkg::axil_aw_t aw,
	input  logic                    awvalid,
	output logic                    awready,
	input  fetch_bus_pkg::axil_w_t  w,
	input  logic                    wvalid,
	output logic                    wready,
	output fetch_bus_pkg::axil_b_t  b,
	output logic                    bvalid,
	input  logic                    bready
);
	import fetch_bus_pkg::*;

	localparam int offset_w = $clog2(`FETCH_LINE_WORDS);
	localparam int index_w  = $clog2(num_lines);
	localparam int word_w   = offset_w + index_w;
	localparam int tag_lsb  = word_w + 2;
	localparam int tag_w    = `FETCH_ADDR_W - tag_lsb;

	logic [`FETCH_ADDR_W-1:0] data_mem [num_lines*`FETCH_LINE_WORDS];
	logic [tag_w-1:0]         tag_mem [num_lines];
	logic [num_lines-1:0]     line_valid;

	logic [index_w-1:0]       rd_index;
	logic [word_w-1:0]        rd_word;
	logic                     rd_hit;

	logic                     aw_held;
	logic                     w_held;
	axil_aw_t                 aw_q;
	axil_w_t                  w_q;
	logic                     aw_fire;
	logic                     w_fire;
	logic                     wr_go;
	logic [`FETCH_ADDR_W-1:0] wr_addr;
	axil_w_t                  wr_beat;
	logic [word_w-1:0]        wr_word;
	logic [index_w-1:0]       wr_index;
	logic                     wr_last;

	// ####################################################################
	// lookup.
	// ####################################################################

	assign rd_index = ar.addr[offset_w+2 +: index_w];
	assign rd_word  = ar.addr[2 +: word_w];
	assign rd_hit   = line_valid[rd_index] && tag_mem[rd_index] == ar.addr[`FETCH_ADDR_W-1:tag_lsb];
	assign arready  = !rvalid;

	always_ff @(posedge clock) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (arvalid && arready) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// miss goes back as slverr.
	always_ff @(posedge clock) begin
		if (arvalid && arready) begin
			r.data <= data_mem[rd_word];
			r.resp <= rd_hit ? OKAY : SLVERR;
		end
	end

	// ####################################################################
	// refill writes.
	// ####################################################################

	assign awready  = !aw_held && !bvalid;
	assign wready   = !w_held && !bvalid;
	assign aw_fire  = awvalid && awready;
	assign w_fire   = wvalid && wready;
	assign wr_go    = (aw_held || aw_fire) && (w_held || w_fire);
	assign wr_addr  = aw_held ? aw_q.addr : aw.addr;
	assign wr_beat  = w_held ? w_q : w;
	assign wr_word  = wr_addr[2 +: word_w];
	assign wr_index = wr_addr[offset_w+2 +: index_w];
	assign wr_last  = &wr_addr[2 +: offset_w];
	assign b.resp   = OKAY;

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_held <= 1'b0;
			w_held  <= 1'b0;
			bvalid  <= 1'b0;
		end else if (wr_go) begin
			aw_held <= 1'b0;
			w_held  <= 1'b0;
			bvalid  <= 1'b1;
		end else begin
			if (aw_fire)
				aw_held <= 1'b1;
			if (w_fire)
				w_held <= 1'b1;
			if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	// channel that arrived first waits here.
	always_ff @(posedge clock) begin
		if (aw_fire)
			aw_q <= aw;
		if (w_fire)
			w_q <= w;
	end

	always_ff @(posedge clock) begin
		if (wr_go) begin
			for (int i = 0; i < `FETCH_ADDR_W/8; i++) begin
				if (wr_beat.strb[i])
					data_mem[wr_word][8*i +: 8] <= wr_beat.data[8*i +: 8];
			end
			if (wr_last)
				tag_mem[wr_index] <= wr_addr[`FETCH_ADDR_W-1:tag_lsb];
		end
	end

	// line stays invalid until its last word lands.
	always_ff @(posedge clock) begin
		if (reset)
			line_valid <= '0;
		else if (wr_go)
			line_valid[wr_index] <= wr_last;
	end

endmodule

//--- hw/ifu.sv
`timescale 1ns/10ps
`include "fetch_defines.svh"

module ifu (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       fetch_valid,
	input  fetch_core_pkg::fetch_req_t fetch_req,
	output logic                       fetch_busy,
	output logic                       inst_valid,
	output fetch_core_pkg::fetch_rsp_t inst_rsp,
	output fetch_bus_pkg::axil_ar_t    icache_ar,
	output logic                       icache_arvalid,
	input  logic                       icache_arready,
	input  fetch_bus_pkg::axil_r_t     icache_r,
	input  logic                       icache_rvalid,
	output logic                       icache_rready,
	output fetch_bus_pkg::axil_aw_t    icache_aw,
	output logic                       icache_awvalid,
	input  logic                       icache_awready,
	output fetch_bus_pkg::axil_w_t     icache_w,
	output logic                       icache_wvalid,
	input  logic                       icache_wready,
	input  fetch_bus_pkg::axil_b_t     icache_b,
	input  logic                       icache_bvalid,
	output logic                       icache_bready,
	output fetch_bus_pkg::axi_ar_t     mem_ar,
	output logic                       mem_arvalid,
	input  logic                       mem_arready,
	input  fetch_bus_pkg::axi_r_t      mem_r,
	input  logic                       mem_rvalid,
	output logic                       mem_rready,
	output logic [31:0]                hit_count,
	output logic [31:0]                miss_count
);
	import fetch_bus_pkg::*;
	import fetch_core_pkg::*;

	localparam int offset_w = $clog2(`FETCH_LINE_WORDS);
	localparam int line_lsb = offset_w + 2;
	localparam logic [offset_w-1:0] last_beat = offset_w'(`FETCH_LINE_WORDS - 1);

	ifu_state_e               state;
	fetch_req_t               req_q;
	logic                     cacheable;
	logic                     cacheable_q;
	logic [offset_w-1:0]      beat_cnt;
	logic [`FETCH_ADDR_W-1:0] line_addr;
	logic [`FETCH_ADDR_W-1:0] refill_addr;
	logic [`FETCH_ADDR_W-1:0] beat_q;
	logic [`FETCH_ADDR_W-1:0] word_q;
	logic                     accept;
	logic                     lookup_done;
	logic                     lookup_hit;
	logic                     beat_fire;
	logic                     b_done;

	assign accept      = fetch_valid && !fetch_busy;
	assign cacheable   = fetch_req.pc >= `FETCH_SDRAM_BASE && fetch_req.pc < `FETCH_SDRAM_LIMIT;
	assign line_addr   = {req_q.pc[`FETCH_ADDR_W-1:line_lsb], {line_lsb{1'b0}}};
	assign lookup_done = icache_rvalid && icache_rready;
	assign lookup_hit  = icache_r.resp == OKAY;
	assign beat_fire   = mem_rvalid && mem_rready;
	assign b_done      = icache_bvalid && icache_bready;

	assign icache_ar.addr = req_q.pc;
	assign icache_rready  = 1'b1;
	assign icache_aw.addr = refill_addr;
	assign icache_w.data  = beat_q;
	assign icache_w.strb  = '1;
	assign icache_bready  = 1'b1;

	// uncached reads are one exact beat.
	assign mem_ar.addr  = cacheable_q ? line_addr : req_q.pc;
	assign mem_ar.burst = cacheable_q ? BURST_INCR : BURST_FIXED;
	assign mem_ar.len   = cacheable_q ? 4'(`FETCH_LINE_WORDS - 1) : 4'd0;

	// ####################################################################
	// control.
	// ####################################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			state          <= IDLE;
			fetch_busy     <= 1'b0;
			inst_valid     <= 1'b0;
			icache_arvalid <= 1'b0;
			icache_awvalid <= 1'b0;
			icache_wvalid  <= 1'b0;
			mem_arvalid    <= 1'b0;
			mem_rready     <= 1'b0;
			beat_cnt       <= '0;
		end else begin
			inst_valid <= 1'b0;
			if (inst_valid)
				fetch_busy <= 1'b0;
			if (icache_arvalid && icache_arready)
				icache_arvalid <= 1'b0;
			if (icache_awvalid && icache_awready)
				icache_awvalid <= 1'b0;
			if (icache_wvalid && icache_wready)
				icache_wvalid <= 1'b0;
			if (mem_arvalid && mem_arready)
				mem_arvalid <= 1'b0;

			case (state)
				IDLE: begin
					if (accept) begin
						fetch_busy <= 1'b1;
						if (cacheable) begin
							icache_arvalid <= 1'b1;
							state          <= LOOKUP;
						end else begin
							mem_arvalid <= 1'b1;
							state       <= MEM_REQ;
						end
					end
				end
				LOOKUP: begin
					if (lookup_done && lookup_hit) begin
						state <= DONE;
					end else if (lookup_done) begin
						mem_arvalid <= 1'b1;
						state       <= MEM_REQ;
					end
				end
				MEM_REQ: begin
					if (mem_arvalid && mem_arready) begin
						mem_rready <= 1'b1;
						beat_cnt   <= '0;
						state      <= MEM_DATA;
					end
				end
				MEM_DATA: begin
					// one beat in flight until its write is answered.
					if (beat_fire) begin
						mem_rready <= 1'b0;
						if (cacheable_q) begin
							icache_awvalid <= 1'b1;
							icache_wvalid  <= 1'b1;
						end else begin
							state <= DONE;
						end
					end
					if (b_done) begin
						if (beat_cnt == last_beat) begin
							state <= DONE;
						end else begin
							beat_cnt   <= beat_cnt + 1'b1;
							mem_rready <= 1'b1;
						end
					end
				end
				DONE: begin
					inst_valid <= 1'b1;
					state      <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ####################################################################
	// datapath.
	// ####################################################################

	always_ff @(posedge clock) begin
		if (accept) begin
			req_q       <= fetch_req;
			cacheable_q <= cacheable;
		end
		if (lookup_done && !lookup_hit)
			refill_addr <= line_addr;
		else if (b_done)
			refill_addr <= refill_addr + 32'd4;
		if (lookup_done && lookup_hit)
			word_q <= icache_r.data;
		if (beat_fire) begin
			beat_q <= mem_r.data;
			// keep the requested word as it streams past.
			if (!cacheable_q || beat_cnt == req_q.pc[line_lsb-1:2])
				word_q <= mem_r.data;
		end
		if (state == DONE)
			inst_rsp.inst <= word_q;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			hit_count  <= '0;
			miss_count <= '0;
		end else if (lookup_done && lookup_hit) begin
			hit_count <= hit_count + 32'd1;
		end else if (lookup_done) begin
			miss_count <= miss_count + 32'd1;
		end
	end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch_top (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       fetch_valid,
	input  fetch_core_pkg::fetch_req_t fetch_req,
	output logic                       fetch_busy,
	output logic                       inst_valid,
	output fetch_core_pkg::fetch_rsp_t inst_rsp,
	output fetch_bus_pkg::axi_ar_t     mem_ar,
	output logic                       mem_arvalid,
	input  logic                       mem_arready,
	input  fetch_bus_pkg::axi_r_t      mem_r,
	input  logic                       mem_rvalid,
	output logic                       mem_rready,
	output logic [31:0]                hit_count,
	output logic [31:0]                miss_count
);
	import fetch_bus_pkg::*;

	axil_ar_t icache_ar;
	logic     icache_arvalid;
	logic     icache_arready;
	axil_r_t  icache_r;
	logic     icache_rvalid;
	logic     icache_rready;
	axil_aw_t icache_aw;
	logic     icache_awvalid;
	logic     icache_awready;
	axil_w_t  icache_w;
	logic     icache_wvalid;
	logic     icache_wready;
	axil_b_t  icache_b;
	logic     icache_bvalid;
	logic     icache_bready;

	ifu ifu0 (
		.clock          (clock),
		.reset          (reset),
		.fetch_valid    (fetch_valid),
		.fetch_req      (fetch_req),
		.fetch_busy     (fetch_busy),
		.inst_valid     (inst_valid),
		.inst_rsp       (inst_rsp),
		.icache_ar      (icache_ar),
		.icache_arvalid (icache_arvalid),
		.icache_arready (icache_arready),
		.icache_r       (icache_r),
		.icache_rvalid  (icache_rvalid),
		.icache_rready  (icache_rready),
		.icache_aw      (icache_aw),
		.icache_awvalid (icache_awvalid),
		.icache_awready (icache_awready),
		.icache_w       (icache_w),
		.icache_wvalid  (icache_wvalid),
		.icache_wready  (icache_wready),
		.icache_b       (icache_b),
		.icache_bvalid  (icache_bvalid),
		.icache_bready  (icache_bready),
		.mem_ar         (mem_ar),
		.mem_arvalid    (mem_arvalid),
		.mem_arready    (mem_arready),
		.mem_r          (mem_r),
		.mem_rvalid     (mem_rvalid),
		.mem_rready     (mem_rready),
		.hit_count      (hit_count),
		.miss_count     (miss_count)
	);

	icache #(
		.num_lines (`FETCH_CACHE_LINES)
	) icache0 (
		.clock   (clock),
		.reset   (reset),
		.ar      (icache_ar),
		.arvalid (icache_arvalid),
		.arready (icache_arready),
		.r       (icache_r),
		.rvalid  (icache_rvalid),
		.rready  (icache_rready),
		.aw      (icache_aw),
		.awvalid (icache_awvalid),
		.awready (icache_awready),
		.w       (icache_w),
		.wvalid  (icache_wvalid),
		.wready  (icache_wready),
		.b       (icache_b),
		.bvalid  (icache_bvalid),
		.bready  (icache_bready)
	);

endmodule

//--- verif/fetch_sva.sv
`timescale 1ns/10ps

module fetch_sva (
	input logic                   clock,
	input logic                   reset,
	input logic                   fetch_busy,
	input logic                   inst_valid,
	input fetch_bus_pkg::axi_ar_t mem_ar,
	input logic                   mem_arvalid,
	input logic                   mem_arready
);
	int fail_count = 0;

	// address stays put until memory takes it.
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_ar))
	else begin
		fail_count++;
		$error("mem_ar dropped or changed before mem_arready");
	end

	rsp_pulse: assert property (@(posedge clock) disable iff (reset)
		inst_valid |=> !inst_valid)
	else begin
		fail_count++;
		$error("inst_valid high for two cycles");
	end

	rsp_busy: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> fetch_busy)
	else begin
		fail_count++;
		$error("inst_valid while fetch_busy low");
	end

endmodule

bind fetch_top fetch_sva sva0 (
	.clock       (clock),
	.reset       (reset),
	.fetch_busy  (fetch_busy),
	.inst_valid  (inst_valid),
	.mem_ar      (mem_ar),
	.mem_arvalid (mem_arvalid),
	.mem_arready (mem_arready)
);

//--- verif/fetch_tb.sv
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch_tb;
	import fetch_bus_pkg::*;
	import fetch_core_pkg::*;

	localparam int timeout_cycles = 200;

	logic        clock;
	logic        reset;
	logic        fetch_valid;
	fetch_req_t  fetch_req;
	logic        fetch_busy;
	logic        inst_valid;
	fetch_rsp_t  inst_rsp;
	axi_ar_t     mem_ar;
	logic        mem_arvalid;
	logic        mem_arready;
	axi_r_t      mem_r;
	logic        mem_rvalid;
	logic        mem_rready;
	logic [31:0] hit_count;
	logic [31:0] miss_count;

	integer      seed = 87440;
	int          errors = 0;
	int          checks = 0;
	int          rsp_count = 0;
	int          ar_count = 0;
	axi_ar_t     last_ar;
	logic [31:0] exp_hits = 0;
	logic [31:0] exp_misses = 0;
	logic [31:0] pending_pc [$];

	// reference cache, one line address per index.
	logic [31:0] model_line [`FETCH_CACHE_LINES];
	bit          model_valid [`FETCH_CACHE_LINES];

	fetch_top dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// mixes the address bits into a data word.
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b1) ^ 32'h0bad_c0de;
	endfunction

	function automatic bit in_window(input logic [31:0] pc);
		return pc >= `FETCH_SDRAM_BASE && pc < `FETCH_SDRAM_LIMIT;
	endfunction

	// hit returns 1, a miss fills the line.
	function automatic bit model_lookup(input logic [31:0] pc);
		logic [31:0] line;
		int          idx;
		line = pc / (4 * `FETCH_LINE_WORDS);
		idx  = line % `FETCH_CACHE_LINES;
		if (model_valid[idx] && model_line[idx] == line)
			return 1'b1;
		model_valid[idx] = 1'b1;
		model_line[idx]  = line;
		return 1'b0;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	// ####################################################################
	// memory model.
	// ####################################################################

	task automatic serve_burst();
		axi_ar_t req;
		int      gap;
		int      waited;
		gap = $random(seed) & 3;
		repeat (gap) begin
			@(posedge clock);
			#1;
		end
		mem_arready = 1'b1;
		@(posedge clock);
		req     = mem_ar;
		last_ar = req;
		ar_count++;
		#1 mem_arready = 1'b0;
		for (int beat = 0; beat <= req.len; beat++) begin
			gap = $random(seed) & 3;
			repeat (gap) begin
				@(posedge clock);
				#1;
			end
			mem_rvalid = 1'b1;
			mem_r.data = mem_word(req.burst == BURST_INCR ? req.addr + 4 * beat : req.addr);
			mem_r.resp = OKAY;
			mem_r.last = beat == req.len;
			waited = 0;
			do begin
				@(posedge clock);
				waited++;
				if (waited > timeout_cycles)
					abort_run("memory beat never taken by mem_rready");
			end while (!mem_rready);
			#1 mem_rvalid = 1'b0;
		end
	endtask

	initial begin : memory_model
		mem_arready = 1'b0;
		mem_rvalid  = 1'b0;
		mem_r       = '0;
		forever begin
			@(posedge clock);
			if (mem_arvalid && !reset) begin
				#1;
				serve_burst();
			end
		end
	end

	// ####################################################################
	// response checking.
	// ####################################################################

	initial begin : compare_responses
		logic [31:0] pc;
		forever begin
			@(posedge clock);
			if (inst_valid && !reset) begin
				if (pending_pc.size() == 0) begin
					errors++;
					$display("response arrived with no fetch outstanding");
				end else begin
					pc = pending_pc.pop_front();
					compare_value("inst_rsp.inst", inst_rsp.inst, mem_word(pc));
					compare_value("hit_count", hit_count, exp_hits);
					compare_value("miss_count", miss_count, exp_misses);
				end
				rsp_count++;
			end
		end
	end

	// one fetch from request to response, then the memory port.
	task automatic run_fetch(input logic [31:0] pc);
		int waited;
		int ar_before;
		int rsp_before;
		bit cached;
		bit hit;
		cached = in_window(pc);
		hit    = 1'b0;
		if (cached)
			hit = model_lookup(pc);
		waited = 0;
		while (fetch_busy) begin
			@(posedge clock);
			#1;
			waited++;
			if (waited > timeout_cycles)
				abort_run("fetch_busy stuck high");
		end
		ar_before  = ar_count;
		rsp_before = rsp_count;
		if (hit)
			exp_hits++;
		else if (cached)
			exp_misses++;
		pending_pc.push_back(pc);
		fetch_valid  = 1'b1;
		fetch_req.pc = pc;
		@(posedge clock);
		#1 fetch_valid = 1'b0;
		waited = 0;
		while (rsp_count == rsp_before) begin
			@(posedge clock);
			#1;
			waited++;
			if (waited > timeout_cycles)
				abort_run("no inst_valid for a fetch");
		end
		if (hit) begin
			compare_value("mem_ar handshakes", ar_count - ar_before, 0);
		end else begin
			compare_value("mem_ar handshakes", ar_count - ar_before, 1);
			compare_value("mem_ar.addr", last_ar.addr,
				cached ? pc & ~(32'd4 * `FETCH_LINE_WORDS - 32'd1) : pc);
			compare_value("mem_ar.burst", last_ar.burst, cached ? BURST_INCR : BURST_FIXED);
			compare_value("mem_ar.len", last_ar.len, cached ? `FETCH_LINE_WORDS - 1 : 0);
		end
	endtask

	initial begin : stimulus
		logic [31:0] pc;
		logic [31:0] rnd;
		reset       = 1'b1;
		fetch_valid = 1'b0;
		fetch_req   = '0;
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;

		compare_value("fetch_busy", fetch_busy, 0);
		compare_value("inst_valid", inst_valid, 0);
		compare_value("mem_arvalid", mem_arvalid, 0);
		compare_value("hit_count", hit_count, 0);
		compare_value("miss_count", miss_count, 0);

		// uncached, both edges of the window too.
		run_fetch(32'h0000_0100);
		run_fetch(32'h0000_0104);
		run_fetch(`FETCH_SDRAM_BASE - 4);
		run_fetch(`FETCH_SDRAM_LIMIT);

		// first touch misses, the rest of the line hits.
		run_fetch(32'ha000_0048);
		for (int i = 0; i < `FETCH_LINE_WORDS; i++)
			run_fetch(32'ha000_0040 + 4 * i);

		// same index, two tags.
		run_fetch(32'ha000_1044);
		run_fetch(32'ha000_0048);
		run_fetch(32'ha000_104c);
		run_fetch(32'ha000_104c);

		for (int i = 0; i < 200; i++) begin
			rnd = $random(seed);
			if (rnd[1:0] == 2'b00)
				pc = rnd & 32'h0000_fffc;
			else
				pc = `FETCH_SDRAM_BASE + (rnd & 32'h0000_03fc);
			run_fetch(pc);
		end

		repeat (4) @(posedge clock);
		errors = errors + dut0.sva0.fail_count;
		$display("fetches %0d, checks %0d, errors %0d", rsp_count, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- src.f
+incdir+hw
hw/fetch_bus_pkg.sv
hw/fetch_core_pkg.sv
hw/icache.sv
hw/ifu.sv
hw/fetch_top.sv
verif/fetch_sva.sv
verif/fetch_tb.sv

//--- Bender.yml
package:
  name: rv32_fetch

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_bus_pkg.sv
      - hw/fetch_core_pkg.sv
      - hw/icache.sv
      - hw/ifu.sv
      - hw/fetch_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/fetch_sva.sv
      - verif/fetch_tb.sv
